/* verilog/game_pkg.sv */
// -------------------------------------------------------------------
// game core constants, bus map, command opcodes and command word
// -------------------------------------------------------------------
`default_nettype none

package game_pkg;

  // -------------------------------------------------------------------
  // game sizes
  localparam int unsigned num_targets = 5;
  localparam int unsigned level_w     = 4;
  localparam int unsigned score_w     = 16;
  // wide enough to hold num_targets itself
  localparam int unsigned count_w     = $clog2(num_targets + 1);

  localparam logic [level_w-1:0] first_level = level_w'(1);
  localparam logic [level_w-1:0] max_level   = level_w'(15);

  // -------------------------------------------------------------------
  // level sequence timing, in pclk cycles
  localparam int unsigned level_delay_cycles = 200;
  localparam int unsigned arm_hold_cycles    = 16;

  localparam int unsigned cnt_w = $clog2((level_delay_cycles > arm_hold_cycles) ?
                                         level_delay_cycles : arm_hold_cycles);
  localparam logic [cnt_w-1:0] delay_last = cnt_w'(level_delay_cycles - 1);
  localparam logic [cnt_w-1:0] hold_last  = cnt_w'(arm_hold_cycles - 1);

  // level controller state codes
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_count = 2'd1;
  localparam logic [1:0] st_rearm = 2'd2;

  // -------------------------------------------------------------------
  // wishbone word addresses
  localparam logic [1:0] adr_status  = 2'd0;
  localparam logic [1:0] adr_score   = 2'd1;
  localparam logic [1:0] adr_command = 2'd2;

  // command opcodes, top nibble of the command word
  localparam logic [3:0] op_hit   = 4'd1;
  localparam logic [3:0] op_bonus = 4'd2;

  // one command word, two readings selected by op
  typedef union packed {
    struct packed {
      logic [3:0]                 op;
      logic [32-4-num_targets-1:0] pad;
      logic [num_targets-1:0]     target_mask;
    } hit_view;
    struct packed {
      logic [3:0]             op;
      logic [32-4-score_w-1:0] pad;
      logic [score_w-1:0]     bonus;
    } bonus_view;
  } cmd_word_u;

endpackage

`default_nettype wire

/* verilog/level_ctrl.sv */
// -------------------------------------------------------------------
// level controller: waits out the level delay once all targets are
// down, raises the level and holds the re-arm pulse
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module level_ctrl (
  input  logic                              pclk,
  input  logic                              rst,
  input  logic [game_pkg::num_targets-1:0]  alive,
  output logic [game_pkg::level_w-1:0]      level,
  output logic                              rearm,
  output logic                              busy
);

  logic [1:0]                   state;
  // shared by the delay phase and the hold phase
  logic [game_pkg::cnt_w-1:0]   cnt;

  assign busy = (state != game_pkg::st_idle);

  // -------------------------------------------------------------------
  // state, counter and level
  always_ff @(posedge pclk) begin
    if (rst) begin
      state <= game_pkg::st_idle;
      cnt   <= '0;
      level <= game_pkg::first_level;
      rearm <= 1'b0;
    end else begin
      case (state)
        game_pkg::st_idle: begin
          cnt <= '0;
          // every target down
          if (alive == '0) begin
            state <= game_pkg::st_count;
          end
        end

        game_pkg::st_count: begin
          if (cnt == game_pkg::delay_last) begin
            cnt   <= '0;
            state <= game_pkg::st_rearm;
            rearm <= 1'b1;
            // stop at the top level
            if (level < game_pkg::max_level) begin
              level <= level + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        game_pkg::st_rearm: begin
          if (cnt == game_pkg::hold_last) begin
            cnt   <= '0;
            state <= game_pkg::st_idle;
            rearm <= 1'b0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        default: begin
          cnt   <= '0;
          state <= game_pkg::st_idle;
          rearm <= 1'b0;
        end
      endcase
    end
  end

  // -------------------------------------------------------------------
  // checks
  level_no_decrease: assert property (
    @(posedge pclk) disable iff (rst)
    level >= $past(level)
  ) else $error("level went down");

  // rearm flop must track the state register
  rearm_not_idle: assert property (
    @(posedge pclk) disable iff (rst)
    !(rearm && (state == game_pkg::st_idle))
  ) else $error("rearm high while idle");

endmodule

`default_nettype wire

/* verilog/target_bank.sv */
// -------------------------------------------------------------------
// target bank: alive flag per target, hit clearing and re-arm, plus
// the count of live targets knocked down this cycle
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module target_bank (
  input  logic                              pclk,
  input  logic                              rst,
  input  logic [game_pkg::num_targets-1:0]  hit_mask,
  input  logic                              rearm,
  output logic [game_pkg::num_targets-1:0]  alive,
  output logic [game_pkg::count_w-1:0]      fallen_count
);

  // hits that land on a live target, none while re-arming
  logic [game_pkg::num_targets-1:0] hit_live;

  assign hit_live = rearm ? '0 : (hit_mask & alive);

  // -------------------------------------------------------------------
  // population count of real knock-downs
  always_comb begin
    fallen_count = '0;
    for (int i = 0; i < game_pkg::num_targets; i++) begin
      fallen_count = fallen_count + {{(game_pkg::count_w - 1){1'b0}}, hit_live[i]};
    end
  end

  // -------------------------------------------------------------------
  // alive flags
  always_ff @(posedge pclk) begin
    if (rst) begin
      alive <= '1;
    end else if (rearm) begin
      // targets pop back up
      alive <= '1;
    end else begin
      alive <= alive & ~hit_live;
    end
  end

  // no points during re-arm
  rearm_no_points: assert property (
    @(posedge pclk) disable iff (rst)
    rearm |-> (fallen_count == '0)
  ) else $error("points during rearm");

endmodule

`default_nettype wire

/* verilog/score_keeper.sv */
// -------------------------------------------------------------------
// score keeper: adds level-weighted points and bonus, saturating
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module score_keeper (
  input  logic                          pclk,
  input  logic                          rst,
  input  logic [game_pkg::level_w-1:0]  level,
  input  logic [game_pkg::count_w-1:0]  fallen_count,
  input  logic                          bonus_valid,
  input  logic [game_pkg::score_w-1:0]  bonus,
  output logic [game_pkg::score_w-1:0]  score
);

  // level times knocked-down targets
  logic [game_pkg::level_w+game_pkg::count_w-1:0] points;
  logic [game_pkg::score_w-1:0]                   bonus_add;
  // two spare bits catch the carry past 16 bits
  logic [game_pkg::score_w+1:0]                   sum;

  assign points = {{game_pkg::count_w{1'b0}}, level} *
                  {{game_pkg::level_w{1'b0}}, fallen_count};

  assign bonus_add = bonus_valid ? bonus : '0;

  assign sum = {2'b00, score} +
               {{(game_pkg::score_w + 2 - game_pkg::level_w - game_pkg::count_w){1'b0}},
                points} +
               {2'b00, bonus_add};

  // -------------------------------------------------------------------
  // accumulator
  always_ff @(posedge pclk) begin
    if (rst) begin
      score <= '0;
    end else if ((fallen_count != '0) || bonus_valid) begin
      if (sum[game_pkg::score_w+1:game_pkg::score_w] != 2'b00) begin
        // clamp at the top
        score <= '1;
      end else begin
        score <= sum[game_pkg::score_w-1:0];
      end
    end
  end

  score_no_decrease: assert property (
    @(posedge pclk) disable iff (rst)
    score >= $past(score)
  ) else $error("score went down");

endmodule

`default_nettype wire

/* verilog/wb_game_regs.sv */
// -------------------------------------------------------------------
// wishbone classic slave: status and score reads, command writes
// decoded into hit and bonus strobes
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module wb_game_regs (
  input  logic                              pclk,
  input  logic                              rst,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [1:0]                        wb_adr,
  input  logic [31:0]                       wb_dat_i,
  output logic [31:0]                       wb_dat_o,
  output logic                              wb_ack,
  input  logic [game_pkg::level_w-1:0]      level,
  input  logic [game_pkg::num_targets-1:0]  alive,
  input  logic                              busy,
  input  logic [game_pkg::score_w-1:0]      score,
  output logic [game_pkg::num_targets-1:0]  hit_mask,
  output logic                              bonus_valid,
  output logic [game_pkg::score_w-1:0]      bonus
);

  game_pkg::cmd_word_u  cmd;
  logic                 req;
  logic                 wr_cmd;
  logic [31:0]          status_word;
  logic [31:0]          rd_data;

  assign cmd = wb_dat_i;

  // new request, not the one already being acked
  assign req    = wb_cyc && wb_stb && !wb_ack;
  assign wr_cmd = req && wb_we && (wb_adr == game_pkg::adr_command);

  // -------------------------------------------------------------------
  // read side
  always_comb begin
    status_word       = '0;
    status_word[16]   = busy;
    status_word[11:8] = level;
    status_word[4:0]  = alive;
  end

  always_comb begin
    case (wb_adr)
      game_pkg::adr_status: rd_data = status_word;
      game_pkg::adr_score:  rd_data = {{(32 - game_pkg::score_w){1'b0}}, score};
      // command is write only, address 3 unused
      default:              rd_data = '0;
    endcase
  end

  // -------------------------------------------------------------------
  // ack and command strobes, all live in the ack cycle
  always_ff @(posedge pclk) begin
    if (rst) begin
      wb_ack      <= 1'b0;
      hit_mask    <= '0;
      bonus_valid <= 1'b0;
    end else begin
      wb_ack      <= req;
      hit_mask    <= '0;
      bonus_valid <= 1'b0;
      if (wr_cmd && (cmd.hit_view.op == game_pkg::op_hit)) begin
        hit_mask <= cmd.hit_view.target_mask;
      end
      if (wr_cmd && (cmd.bonus_view.op == game_pkg::op_bonus)) begin
        bonus_valid <= 1'b1;
      end
    end
  end

  // data words
  always_ff @(posedge pclk) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
    if (wr_cmd) begin
      bonus <= cmd.bonus_view.bonus;
    end
  end

  ack_single_cycle: assert property (
    @(posedge pclk) disable iff (rst)
    wb_ack |=> !wb_ack
  ) else $error("ack held for two cycles");

endmodule

`default_nettype wire

/* verilog/game_core.sv */
// -------------------------------------------------------------------
// game logic core: targets, score, level control and host registers
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module game_core (
  input  logic         pclk,
  input  logic         rst,
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  logic [1:0]   wb_adr,
  input  logic [31:0]  wb_dat_i,
  output logic [31:0]  wb_dat_o,
  output logic         wb_ack,
  // re-arm pulse, also the level-up indicator
  output logic         level_up
);

  logic [game_pkg::num_targets-1:0]  alive;
  logic [game_pkg::count_w-1:0]      fallen_count;
  logic [game_pkg::level_w-1:0]      level;
  logic                              busy;
  logic [game_pkg::score_w-1:0]      score;
  logic [game_pkg::num_targets-1:0]  hit_mask;
  logic                              bonus_valid;
  logic [game_pkg::score_w-1:0]      bonus;

  level_ctrl level_ctrl_inst (
    .pclk  (pclk),
    .rst   (rst),
    .alive (alive),
    .level (level),
    .rearm (level_up),
    .busy  (busy)
  );

  target_bank target_bank_inst (
    .pclk         (pclk),
    .rst          (rst),
    .hit_mask     (hit_mask),
    .rearm        (level_up),
    .alive        (alive),
    .fallen_count (fallen_count)
  );

  score_keeper score_keeper_inst (
    .pclk         (pclk),
    .rst          (rst),
    .level        (level),
    .fallen_count (fallen_count),
    .bonus_valid  (bonus_valid),
    .bonus        (bonus),
    .score        (score)
  );

  wb_game_regs wb_game_regs_inst (
    .pclk        (pclk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack      (wb_ack),
    .level       (level),
    .alive       (alive),
    .busy        (busy),
    .score       (score),
    .hit_mask    (hit_mask),
    .bonus_valid (bonus_valid),
    .bonus       (bonus)
  );

endmodule

`default_nettype wire

/* verification/game_core_tb.sv */
// -------------------------------------------------------------------
// game core testbench: directed tests checked against a reference model
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module game_core_tb;

  localparam int cycle_limit =
    10 * (game_pkg::level_delay_cycles + game_pkg::arm_hold_cycles) + 2000;
  localparam logic [31:0] score_max = (32'd1 << game_pkg::score_w) - 32'd1;

  logic         pclk;
  logic         rst;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  logic [1:0]   wb_adr;
  logic [31:0]  wb_dat_i;
  logic [31:0]  wb_dat_o;
  logic         wb_ack;
  logic         level_up;

  // reference model state
  logic [game_pkg::level_w-1:0]      exp_level;
  logic [game_pkg::num_targets-1:0]  exp_alive;
  logic [game_pkg::score_w-1:0]      exp_score;

  int     error_count;
  int     check_count;
  int     cycle_count;
  integer seed;

  game_core game_core_inst (
    .pclk     (pclk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .level_up (level_up)
  );

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  // -------------------------------------------------------------------
  // compare tasks
  task automatic check_level(input string name, input logic [game_pkg::level_w-1:0] exp_v,
                             input logic [game_pkg::level_w-1:0] act_v);
    check_count++;
    if (act_v !== exp_v) begin
      error_count++;
      $display("[FAIL] %s: level expected %0d, got %0d", name, exp_v, act_v);
    end
  endtask

  task automatic check_alive(input string name, input logic [game_pkg::num_targets-1:0] exp_v,
                             input logic [game_pkg::num_targets-1:0] act_v);
    check_count++;
    if (act_v !== exp_v) begin
      error_count++;
      $display("[FAIL] %s: alive expected %b, got %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_score(input string name, input logic [game_pkg::score_w-1:0] exp_v,
                             input logic [game_pkg::score_w-1:0] act_v);
    check_count++;
    if (act_v !== exp_v) begin
      error_count++;
      $display("[FAIL] %s: score expected %0d, got %0d", name, exp_v, act_v);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    check_count++;
    if (act_v !== exp_v) begin
      error_count++;
      $display("[FAIL] %s: flag expected %b, got %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
    check_count++;
    if (act_v !== exp_v) begin
      error_count++;
      $display("[FAIL] %s: word expected %h, got %h", name, exp_v, act_v);
    end
  endtask

  // -------------------------------------------------------------------
  // wishbone master
  task automatic wait_ack();
    @(negedge pclk);
    while (!wb_ack) @(negedge pclk);
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    @(posedge pclk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_i <= data;
    wait_ack();
    @(posedge pclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    @(posedge pclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack();
    data = wb_dat_o;
    @(posedge pclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // -------------------------------------------------------------------
  // model helpers
  function automatic int count_ones(input logic [game_pkg::num_targets-1:0] m);
    int c;
    c = 0;
    for (int i = 0; i < game_pkg::num_targets; i++) c += int'(m[i]);
    return c;
  endfunction

  task automatic add_points(input logic [31:0] pts);
    logic [31:0] sum;
    sum = 32'(exp_score) + pts;
    exp_score = (sum > score_max) ? '1 : sum[game_pkg::score_w-1:0];
  endtask

  task automatic check_state(input string name);
    logic [31:0] st;
    logic [31:0] sc;
    wb_read(game_pkg::adr_status, st);
    wb_read(game_pkg::adr_score, sc);
    check_level(name, exp_level, st[11:8]);
    check_alive(name, exp_alive, st[4:0]);
    check_score(name, exp_score, sc[game_pkg::score_w-1:0]);
  endtask

  task automatic hit_and_check(input string name, input logic [game_pkg::num_targets-1:0] mask);
    game_pkg::cmd_word_u cmd;
    cmd = '0;
    cmd.hit_view.op = game_pkg::op_hit;
    cmd.hit_view.target_mask = mask;
    wb_write(game_pkg::adr_command, cmd);
    add_points(32'(exp_level) * 32'(count_ones(mask & exp_alive)));
    exp_alive = exp_alive & ~mask;
    check_state(name);
  endtask

  task automatic bonus_and_check(input string name, input logic [game_pkg::score_w-1:0] b);
    game_pkg::cmd_word_u cmd;
    cmd = '0;
    cmd.bonus_view.op = game_pkg::op_bonus;
    cmd.bonus_view.bonus = b;
    wb_write(game_pkg::adr_command, cmd);
    add_points(32'(b));
    check_state(name);
  endtask

  task automatic wait_level_rise();
    @(negedge pclk);
    while (!level_up) @(negedge pclk);
  endtask

  task automatic wait_level_fall();
    @(negedge pclk);
    while (level_up) @(negedge pclk);
    if (exp_level < game_pkg::max_level) exp_level = exp_level + 1'b1;
    exp_alive = '1;
  endtask

  // -------------------------------------------------------------------
  // directed tests
  task automatic test_reset();
    logic [31:0] st;
    check_flag("reset level_up", 1'b0, level_up);
    wb_read(game_pkg::adr_status, st);
    check_flag("reset busy", 1'b0, st[16]);
    check_state("reset");
  endtask

  task automatic test_partial_hits();
    hit_and_check("partial_hits a", 5'b00011);
    hit_and_check("partial_hits b", 5'b00110);
    // all already down
    hit_and_check("partial_hits c", 5'b00011);
    hit_and_check("partial_hits d", 5'b01000);
  endtask

  task automatic test_level_up();
    logic [31:0] st;
    hit_and_check("level_up knock", '1);
    wb_read(game_pkg::adr_status, st);
    check_flag("level_up busy high", 1'b1, st[16]);
    wait_level_rise();
    wait_level_fall();
    check_state("level_up after");
    wb_read(game_pkg::adr_status, st);
    check_flag("level_up busy low", 1'b0, st[16]);
  endtask

  task automatic test_bus_edges();
    logic [31:0]         rd;
    game_pkg::cmd_word_u cmd;
    wb_read(2'd3, rd);
    check_word("bus_edges adr3 read", 32'd0, rd);
    cmd = '0;
    cmd.hit_view.op = 4'd7;
    cmd.hit_view.target_mask = '1;
    wb_write(game_pkg::adr_command, cmd);
    check_state("bus_edges bad opcode");
    cmd.hit_view.op = game_pkg::op_hit;
    wb_write(2'd3, cmd);
    check_state("bus_edges adr3 write");
    // hits during the re-arm pulse
    hit_and_check("bus_edges knock", '1);
    wait_level_rise();
    wb_write(game_pkg::adr_command, cmd);
    wb_read(game_pkg::adr_status, rd);
    check_alive("bus_edges rearm hit", '1, rd[4:0]);
    wait_level_fall();
    check_state("bus_edges after rearm");
  endtask

  task automatic test_random_play();
    logic [31:0] rnd;
    int          ups;
    int          iters;
    ups = 0;
    iters = 0;
    while (ups < 3 && iters < 200) begin
      rnd = $random(seed);
      hit_and_check("random_play", rnd[game_pkg::num_targets-1:0]);
      if (exp_alive == '0) begin
        wait_level_rise();
        wait_level_fall();
        check_state("random_play level");
        ups++;
      end
      iters++;
    end
  endtask

  task automatic test_bonus_saturation();
    logic [31:0] sc;
    bonus_and_check("bonus exact", 16'd1234);
    bonus_and_check("bonus sat a", 16'h7fff);
    bonus_and_check("bonus sat b", 16'h7fff);
    bonus_and_check("bonus sat c", 16'h7fff);
    // three large bonuses are past the top whatever came before
    wb_read(game_pkg::adr_score, sc);
    check_score("bonus saturated", 16'hffff, sc[game_pkg::score_w-1:0]);
  endtask

  // -------------------------------------------------------------------
  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge pclk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = 2'd0;
    wb_dat_i    = 32'd0;
    error_count = 0;
    check_count = 0;
    seed        = 32'h14368412;
    exp_level   = game_pkg::first_level;
    exp_alive   = '1;
    exp_score   = '0;
    repeat (10) @(posedge pclk);
    rst <= 1'b0;
    test_reset();
    test_partial_hits();
    test_level_up();
    test_bus_edges();
    test_random_play();
    test_bonus_saturation();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
verilog/game_pkg.sv
verilog/level_ctrl.sv
verilog/target_bank.sv
verilog/score_keeper.sv
verilog/wb_game_regs.sv
verilog/game_core.sv
verification/game_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the game core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module game_core_tb -o game_core_sim \
  && ./obj_dir/game_core_sim | tee /dev/stderr | grep -F "All tests passed" > /dev/null \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
